// File: mipsTestdata.txt
# P <hex word>: program word, loaded from instruction address 0 upward
# E <reg> <hex value>: expected writeback, in order; N <count>: cycles to run
#
# ---- alu and addi ----
P 2001000c  # 00 addi $1, $0, 12
P 2002fffd  # 04 addi $2, $0, -3
P 00221820  # 08 add  $3, $1, $2
P 00222022  # 0c sub  $4, $1, $2
P 00222824  # 10 and  $5, $1, $2
P 00223025  # 14 or   $6, $1, $2
P 0041382a  # 18 slt  $7, $2, $1
P 0022402a  # 1c slt  $8, $1, $2
# ---- loads and stores ----
P ac040008  # 20 sw   $4, 8($0)
P 8c090008  # 24 lw   $9, 8($0)
P 8c0a0010  # 28 lw   $10, 16($0)
# ---- branches ----
P 10210001  # 2c beq  $1, $1, +1
P 200b0001  # 30 addi $11, $0, 1   skipped
P 10220001  # 34 beq  $1, $2, +1
P 200c0007  # 38 addi $12, $0, 7
# ---- jumps ----
P 08000012  # 3c j    0x48
P 200d0001  # 40 addi $13, $0, 1   skipped
P 200e0001  # 44 addi $14, $0, 1   skipped
P 0c000015  # 48 jal  0x54
P 200f0001  # 4c addi $15, $0, 1   skipped
P 20100001  # 50 addi $16, $0, 1   skipped
# ---- register zero ----
P 20000063  # 54 addi $0, $0, 99
P 00018820  # 58 add  $17, $0, $1
#
# ---- expected writebacks ----
E 1 0000000c
E 2 fffffffd
E 3 00000009
E 4 0000000f
E 5 0000000c
E 6 fffffffd
E 7 00000001
E 8 00000000
E 9 0000000f
E 10 00000000
E 12 00000007
E 31 0000004c
E 0 00000063
E 17 0000000c
N 30

// File: files.f
mipsPkg.sv
controlUnit.sv
aluUnit.sv
regFile.sv
pcUnit.sv
instrMem.sv
dataMem.sv
mipsCore.sv
mipsSystem.sv
tbMipsSystem.sv

// File: runSim.sh
#!/bin/sh
# build with verilator, run, then judge the log

rm -rf obj_dir sim.log

verilator --binary --assert --timing --timescale 1ns/100ps \
  --top-module tbMipsSystem -f files.f > build.log 2>&1 \
  && ./obj_dir/VtbMipsSystem > sim.log 2>&1 \
  || echo "SOME TESTS FAILED (build or simulation error, see build.log)" >> sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
  echo "simulation failed, see sim.log"
  exit 1
fi
echo "simulation passed"
exit 0

// File: tbMipsSystem.sv
module tbMipsSystem;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int imemDepth = 64;
  localparam int dmemDepth = 64;
  localparam int imemAw    = $clog2(imemDepth);
  // longest run of cycles without a register write that the program may show
  localparam int maxGap    = 8;

  logic              clk;
  logic              rst;
  logic              run;
  logic              progWe;
  logic [imemAw-1:0] progAddr;
  mipsPkg::word      progData;
  logic              wbValid;
  mipsPkg::regAddr   wbAddr;
  mipsPkg::word      wbData;
  mipsPkg::word      pc;

  // contents of the testdata file
  mipsPkg::word    progQ[$];
  mipsPkg::regAddr expAddrQ[$];
  mipsPkg::word    expDataQ[$];
  int              runCycles;
  // next expected writeback
  int              expIdx;

  mipsSystem #(.imemDepth(imemDepth), .dmemDepth(dmemDepth)) dut_i (
    .clk      (clk),
    .rst      (rst),
    .run      (run),
    .progWe   (progWe),
    .progAddr (progAddr),
    .progData (progData),
    .wbValid  (wbValid),
    .wbAddr   (wbAddr),
    .wbData   (wbData),
    .pc       (pc)
  );

  always #5 clk = ~clk;

  // ==================================================
  // failure paths
  // ==================================================
  task automatic stopWithFailure();
    $display("SOME TESTS FAILED");
    $fatal(1, "testbench stopped at the first failure");
  endtask

  // wrong value seen on the DUT
  task automatic reportMismatch(input string msg);
    $display("ERROR at %0d ns: %s", $time, msg);
    stopWithFailure();
  endtask

  task automatic reportFailure(input string msg);
    $display("%s", msg);
    stopWithFailure();
  endtask

  // ==================================================
  // testdata file
  // ==================================================
  task automatic readTestdata();
    int           fd;
    int           code;
    int           regIdx;
    string        line;
    mipsPkg::word val;
    fd = $fopen("mipsTestdata.txt", "r");
    if (fd == 0) reportFailure("could not open mipsTestdata.txt");
    runCycles = 0;
    while (!$feof(fd)) begin
      code = $fgets(line, fd);
      if (code == 0) break;
      // blank and comment lines
      if (line.len() < 2 || line[0] == "#") continue;
      case (line[0])
        "P": begin
          code = $sscanf(line.substr(1, line.len() - 1), "%h", val);
          if (code != 1) reportFailure("testdata program line is malformed");
          progQ.push_back(val);
        end
        "E": begin
          code = $sscanf(line.substr(1, line.len() - 1), "%d %h", regIdx, val);
          if (code != 2 || regIdx < 0 || regIdx > 31) begin
            reportFailure("testdata expected line is malformed");
          end
          expAddrQ.push_back(5'(regIdx));
          expDataQ.push_back(val);
        end
        "N": begin
          code = $sscanf(line.substr(1, line.len() - 1), "%d", runCycles);
          if (code != 1) reportFailure("testdata cycle count line is malformed");
        end
        default: reportFailure("testdata holds a line of unknown kind");
      endcase
    end
    $fclose(fd);
    if (progQ.size() > imemDepth) reportFailure("program does not fit instruction memory");
    if (runCycles <= 0) reportFailure("testdata gives no cycle count");
  endtask

  // ==================================================
  // stimulus and checks
  // ==================================================
  // one word per clock through the load port
  task automatic loadProgram();
    for (int i = 0; i < progQ.size(); i++) begin
      @(posedge clk);
      progWe   <= 1'b1;
      progAddr <= imemAw'(i);
      progData <= progQ[i];
    end
    @(posedge clk);
    progWe <= 1'b0;
  endtask

  // run low, so pc must stand still and the trace stay quiet
  task automatic checkHalted(input int cycles);
    mipsPkg::word heldPc;
    @(negedge clk);
    heldPc = pc;
    for (int i = 0; i < cycles; i++) begin
      @(negedge clk);
      assert (!wbValid && pc == heldPc)
        else reportMismatch($sformatf("halted core shows wbValid %b, pc %h, held pc %h",
                                      wbValid, pc, heldPc));
    end
  endtask

  task automatic runAndCheck();
    int cyc;
    int gap;
    cyc = 0;
    gap = 0;
    @(posedge clk);
    run <= 1'b1;
    while (cyc < runCycles) begin
      // trace is stable mid cycle
      @(negedge clk);
      cyc++;
      if (wbValid) begin
        gap = 0;
        assert (expIdx < expAddrQ.size())
          else reportMismatch($sformatf("unexpected write r%0d = %h", wbAddr, wbData));
        assert (wbAddr == expAddrQ[expIdx] && wbData == expDataQ[expIdx])
          else reportMismatch($sformatf("write %0d expected r%0d = %h, got r%0d = %h",
                                        expIdx, expAddrQ[expIdx], expDataQ[expIdx],
                                        wbAddr, wbData));
        expIdx++;
      end else if (expIdx < expAddrQ.size()) begin
        gap++;
        if (gap > maxGap) begin
          reportFailure($sformatf("timeout: no register write for %0d cycles at pc %h", gap, pc));
        end
      end
    end
    @(posedge clk);
    run <= 1'b0;
  endtask

  initial begin
    clk      = 1'b0;
    rst      = 1'b0;
    run      = 1'b0;
    progWe   = 1'b0;
    progAddr = '0;
    progData = '0;
    expIdx   = 0;
    readTestdata();
    repeat (4) @(posedge clk);
    rst <= 1'b1;
    @(negedge clk);
    assert (pc == 32'd0 && !wbValid)
      else reportMismatch($sformatf("after reset pc %h, wbValid %b", pc, wbValid));
    loadProgram();
    // word 0 is a register write, it must stay invisible until run rises
    checkHalted(3);
    runAndCheck();
    checkHalted(3);
    if (expIdx == expAddrQ.size()) begin
      $display("ALL TESTS PASSED");
      $finish;
    end else begin
      reportFailure($sformatf("%0d expected writebacks never appeared",
                              expAddrQ.size() - expIdx));
    end
  end

endmodule

// File: mipsSystem.sv
module mipsSystem #(
  parameter int unsigned imemDepth = 64,
  parameter int unsigned dmemDepth = 64
) (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         run,
  input  logic                         progWe,
  input  logic [$clog2(imemDepth)-1:0] progAddr,
  input  mipsPkg::word                 progData,
  output logic                         wbValid,
  output mipsPkg::regAddr              wbAddr,
  output mipsPkg::word                 wbData,
  output mipsPkg::word                 pc
);

  // fetch path
  logic [$clog2(imemDepth)-1:0] imemAddr;
  mipsPkg::word                 instr;

  // load/store path
  logic [$clog2(dmemDepth)-1:0] dmemAddr;
  mipsPkg::word                 dmemWdata, dmemRdata;
  logic                         dmemWe;

  mipsCore #(.imemDepth(imemDepth), .dmemDepth(dmemDepth)) core_i (
    .clk       (clk),
    .rst       (rst),
    .run       (run),
    .instr     (instr),
    .imemAddr  (imemAddr),
    .dmemRdata (dmemRdata),
    .dmemAddr  (dmemAddr),
    .dmemWdata (dmemWdata),
    .dmemWe    (dmemWe),
    .wbValid   (wbValid),
    .wbAddr    (wbAddr),
    .wbData    (wbData),
    .pc        (pc)
  );

  instrMem #(.imemDepth(imemDepth)) imem_i (
    .clk      (clk),
    .addr     (imemAddr),
    .progWe   (progWe),
    .progAddr (progAddr),
    .progData (progData),
    .instr    (instr)
  );

  dataMem #(.dmemDepth(dmemDepth)) dmem_i (
    .clk   (clk),
    .rst   (rst),
    .addr  (dmemAddr),
    .wData (dmemWdata),
    .we    (dmemWe),
    .rData (dmemRdata)
  );

endmodule

// File: mipsCore.sv
module mipsCore #(
  parameter int unsigned imemDepth = 64,
  parameter int unsigned dmemDepth = 64
) (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         run,
  input  mipsPkg::word                 instr,
  output logic [$clog2(imemDepth)-1:0] imemAddr,
  input  mipsPkg::word                 dmemRdata,
  output logic [$clog2(dmemDepth)-1:0] dmemAddr,
  output mipsPkg::word                 dmemWdata,
  output logic                         dmemWe,
  output logic                         wbValid,
  output mipsPkg::regAddr              wbAddr,
  output mipsPkg::word                 wbData,
  output mipsPkg::word                 pc
);

  localparam int imemAw = $clog2(imemDepth);
  localparam int dmemAw = $clog2(dmemDepth);

  // ==================================================
  // decode
  // ==================================================
  mipsPkg::instrWord iw;
  mipsPkg::word      immExt;
  mipsPkg::aluOp     aluCtl;
  logic regDst, aluSrc, memToReg, regWrite;
  logic memWrite, branch, jump, link;

  assign iw     = instr;
  assign immExt = {{16{iw.iFields.imm16[15]}}, iw.iFields.imm16};

  controlUnit ctrl_i (
    .op       (iw.rFields.op),
    .funct    (iw.rFields.funct),
    .regDst   (regDst),
    .aluSrc   (aluSrc),
    .memToReg (memToReg),
    .regWrite (regWrite),
    .memWrite (memWrite),
    .branch   (branch),
    .jump     (jump),
    .link     (link),
    .aluOp    (aluCtl)
  );

  // ==================================================
  // registers and alu
  // ==================================================
  mipsPkg::word    rData1, rData2, aluB, aluResult, pcPlus4;
  mipsPkg::regAddr writeReg;
  logic            aluZero, regWe, branchTaken;

  // destination: $ra for jal, rd for r-type, else rt
  assign writeReg = link ? mipsPkg::linkReg : (regDst ? iw.rFields.rd : iw.rFields.rt);
  assign wbData   = link ? pcPlus4 : (memToReg ? dmemRdata : aluResult);

  // nothing commits while halted
  assign regWe = regWrite & run;

  regFile rf_i (
    .clk    (clk),
    .rst    (rst),
    .we     (regWe),
    .rAddr1 (iw.rFields.rs),
    .rAddr2 (iw.rFields.rt),
    .wAddr  (writeReg),
    .wData  (wbData),
    .rData1 (rData1),
    .rData2 (rData2)
  );

  assign aluB = aluSrc ? immExt : rData2;

  aluUnit alu_i (
    .a      (rData1),
    .b      (aluB),
    .aluOp  (aluCtl),
    .result (aluResult),
    .zero   (aluZero)
  );

  assign branchTaken = branch & aluZero;

  pcUnit pc_i (
    .clk          (clk),
    .rst          (rst),
    .run          (run),
    .branchTaken  (branchTaken),
    .jump         (jump),
    .jumpTarget   (iw.jFields.target26),
    .branchOffset (immExt),
    .pc           (pc),
    .pcPlus4      (pcPlus4)
  );

  // memory side, byte addresses turned into word indices
  assign imemAddr  = pc[imemAw+1:2];
  assign dmemAddr  = aluResult[dmemAw+1:2];
  assign dmemWdata = rData2;
  assign dmemWe    = memWrite & run;

  // trace port
  assign wbValid = regWe;
  assign wbAddr  = writeReg;

endmodule

// File: dataMem.sv
module dataMem #(
  parameter int unsigned dmemDepth = 64
) (
  input  logic                         clk,
  input  logic                         rst,
  input  logic [$clog2(dmemDepth)-1:0] addr,
  input  mipsPkg::word                 wData,
  input  logic                         we,
  output mipsPkg::word                 rData
);

  mipsPkg::word mem [dmemDepth];

  // ==================================================
  // storage, cleared so untouched words load as zero
  // ==================================================
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      for (int i = 0; i < dmemDepth; i++) begin
        mem[i] <= '0;
      end
    end else if (we) begin
      mem[addr] <= wData;
    end
  end

  // combinational read, lw sees it in the same cycle
  assign rData = (32'(addr) < dmemDepth) ? mem[addr] : '0;

  // stores from the core must land inside the array
  a_addrRange : assert property (@(posedge clk) disable iff (!rst)
    we |-> (32'(addr) < dmemDepth))
    else $error("dataMem: store to word %0d beyond depth", addr);

endmodule

// File: instrMem.sv
module instrMem #(
  parameter int unsigned imemDepth = 64
) (
  input  logic                         clk,
  input  logic [$clog2(imemDepth)-1:0] addr,
  input  logic                         progWe,
  input  logic [$clog2(imemDepth)-1:0] progAddr,
  input  mipsPkg::word                 progData,
  output mipsPkg::word                 instr
);

  // program storage
  mipsPkg::word mem [imemDepth];

  // all-zero word is sll $0,$0,0, so unloaded slots act as no-ops
  initial begin
    for (int i = 0; i < imemDepth; i++) begin
      mem[i] = '0;
    end
  end

  // program load, one word per clock
  always_ff @(posedge clk) begin
    if (progWe) begin
      mem[progAddr] <= progData;
    end
  end

  // fetch in the same cycle
  // out of range only when depth is not a power of two
  assign instr = (32'(addr) < imemDepth) ? mem[addr] : '0;

endmodule

// File: pcUnit.sv
module pcUnit (
  input  logic         clk,
  input  logic         rst,
  input  logic         run,
  input  logic         branchTaken,
  input  logic         jump,
  input  logic [25:0]  jumpTarget,
  input  mipsPkg::word branchOffset,
  output mipsPkg::word pc,
  output mipsPkg::word pcPlus4
);

  mipsPkg::word pcNext;
  mipsPkg::word branchAddr;
  mipsPkg::word jumpAddr;

  assign pcPlus4 = pc + 32'd4;

  // offset counts words
  assign branchAddr = pcPlus4 + {branchOffset[29:0], 2'b00};

  // pseudo-direct, region taken from pc+4
  assign jumpAddr = {pcPlus4[31:28], jumpTarget, 2'b00};

  // ==================================================
  // next address, jump wins over branch
  // ==================================================
  always_comb begin
    if (jump) begin
      pcNext = jumpAddr;
    end else if (branchTaken) begin
      pcNext = branchAddr;
    end else begin
      pcNext = pcPlus4;
    end
  end

  // hold while run is low
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      pc <= '0;
    end else if (run) begin
      pc <= pcNext;
    end
  end

  a_pcAligned : assert property (@(posedge clk) disable iff (!rst) pc[1:0] == 2'b00)
    else $error("pcUnit: unaligned pc %h", pc);

endmodule

// File: regFile.sv
module regFile (
  input  logic            clk,
  input  logic            rst,
  input  logic            we,
  input  mipsPkg::regAddr rAddr1,
  input  mipsPkg::regAddr rAddr2,
  input  mipsPkg::regAddr wAddr,
  input  mipsPkg::word    wData,
  output mipsPkg::word    rData1,
  output mipsPkg::word    rData2
);

  // 32 general purpose registers
  mipsPkg::word regs [32];

  // ==================================================
  // write port
  // ==================================================
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && (wAddr != 5'd0)) begin
      // writes to $zero are dropped here
      regs[wAddr] <= wData;
    end
  end

  // read ports, $zero forced
  assign rData1 = (rAddr1 == 5'd0) ? '0 : regs[rAddr1];
  assign rData2 = (rAddr2 == 5'd0) ? '0 : regs[rAddr2];

  // register 0 stays zero across any sequence of writes
  a_regZero : assert property (@(posedge clk) disable iff (!rst) regs[0] == '0)
    else $error("regFile: register 0 holds %h", regs[0]);

endmodule

// File: aluUnit.sv
module aluUnit (
  input  mipsPkg::word  a,
  input  mipsPkg::word  b,
  input  mipsPkg::aluOp aluOp,
  output mipsPkg::word  result,
  output logic          zero
);

  // signed views for slt
  logic signed [31:0] aSigned;
  logic signed [31:0] bSigned;

  assign aSigned = a;
  assign bSigned = b;

  // ==================================================
  // operation select
  // ==================================================
  always_comb begin
    case (aluOp)
      mipsPkg::aluAdd: result = a + b;
      mipsPkg::aluSub: result = a - b;
      mipsPkg::aluAnd: result = a & b;
      mipsPkg::aluOr:  result = a | b;
      // signed compare, 1 or 0
      mipsPkg::aluSlt: result = {31'd0, aSigned < bSigned};
      default:         result = '0;
    endcase
  end

  // zero flag for every op, beq reads it after sub
  assign zero = (result == '0);

endmodule

// File: controlUnit.sv
module controlUnit (
  input  logic [5:0]     op,
  input  logic [5:0]     funct,
  output logic           regDst,
  output logic           aluSrc,
  output logic           memToReg,
  output logic           regWrite,
  output logic           memWrite,
  output logic           branch,
  output logic           jump,
  output logic           link,
  output mipsPkg::aluOp  aluOp
);

  // main decode and alu decode in one place
  always_comb begin
    // default is no write and no flow change
    regDst   = 1'b0;
    aluSrc   = 1'b0;
    memToReg = 1'b0;
    regWrite = 1'b0;
    memWrite = 1'b0;
    branch   = 1'b0;
    jump     = 1'b0;
    link     = 1'b0;
    aluOp    = mipsPkg::aluAdd;
    case (op)
      mipsPkg::opR: begin
        regDst   = 1'b1;
        regWrite = 1'b1;
        case (funct)
          mipsPkg::fnAdd: aluOp = mipsPkg::aluAdd;
          mipsPkg::fnSub: aluOp = mipsPkg::aluSub;
          mipsPkg::fnAnd: aluOp = mipsPkg::aluAnd;
          mipsPkg::fnOr:  aluOp = mipsPkg::aluOr;
          mipsPkg::fnSlt: aluOp = mipsPkg::aluSlt;
          // unknown funct codes write nothing
          default: regWrite = 1'b0;
        endcase
      end
      mipsPkg::opAddi: begin
        aluSrc   = 1'b1;
        regWrite = 1'b1;
      end
      mipsPkg::opLw: begin
        // address is rs + imm
        aluSrc   = 1'b1;
        memToReg = 1'b1;
        regWrite = 1'b1;
      end
      mipsPkg::opSw: begin
        aluSrc   = 1'b1;
        memWrite = 1'b1;
      end
      mipsPkg::opBeq: begin
        // compare by subtraction and let the zero flag decide
        branch = 1'b1;
        aluOp  = mipsPkg::aluSub;
      end
      mipsPkg::opJ: jump = 1'b1;
      mipsPkg::opJal: begin
        jump     = 1'b1;
        link     = 1'b1;
        regWrite = 1'b1;
      end
      default: ;
    endcase
  end

  // a store never retires a register write in the same instruction
  always_comb begin
    assert (!(memWrite && regWrite))
      else $error("controlUnit: memWrite and regWrite both set, op %h", op);
  end

endmodule

// File: mipsPkg.sv
package mipsPkg;

  // ==================================================
  // basic types
  // ==================================================

  // data word, also used for addresses
  typedef logic [31:0] word;

  // register index
  typedef logic [4:0] regAddr;

  // jal writes its return address here
  localparam regAddr linkReg = 5'd31;

  // ==================================================
  // opcode field, bits 31:26
  // ==================================================

  localparam logic [5:0] opR    = 6'h00;
  localparam logic [5:0] opJ    = 6'h02;
  localparam logic [5:0] opJal  = 6'h03;
  localparam logic [5:0] opBeq  = 6'h04;
  localparam logic [5:0] opAddi = 6'h08;
  localparam logic [5:0] opLw   = 6'h23;
  localparam logic [5:0] opSw   = 6'h2B;

  // funct field of r-type, bits 5:0
  localparam logic [5:0] fnAdd = 6'h20;
  localparam logic [5:0] fnSub = 6'h22;
  localparam logic [5:0] fnAnd = 6'h24;
  localparam logic [5:0] fnOr  = 6'h25;
  localparam logic [5:0] fnSlt = 6'h2A;

  // ==================================================
  // alu operations
  // ==================================================

  typedef enum logic [3:0] {
    aluAdd = 4'd0,
    aluSub = 4'd1,
    aluAnd = 4'd2,
    aluOr  = 4'd3,
    aluSlt = 4'd4
  } aluOp;

  // ==================================================
  // instruction word, three views of the same bits
  // ==================================================

  typedef union packed {
    // r-type: register operands and funct
    struct packed {
      logic [5:0] op;
      regAddr     rs;
      regAddr     rt;
      regAddr     rd;
      logic [4:0] shamt;
      logic [5:0] funct;
    } rFields;
    // i-type: addi, lw, sw, beq
    struct packed {
      logic [5:0]  op;
      regAddr      rs;
      regAddr      rt;
      logic [15:0] imm16;
    } iFields;
    // j-type: j, jal
    struct packed {
      logic [5:0]  op;
      logic [25:0] target26;
    } jFields;
  } instrWord;

endpackage
